/* filelist.f */
rd_tlp_pkg.sv
rd_stream_fifo.sv
rd_tag_tracker.sv
rd_req_tlp_gen.sv
rd_cpl_proc.sv
rd_tlp_top.sv
tb_clock_gen.sv
tb_rd_tlp.sv

/* run.sh */
#!/bin/sh
# Build and run the read TLP testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_rd_tlp -o tb_rd_tlp \
    && ./obj_dir/tb_rd_tlp > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

/* tb_rd_tlp.sv */
// Testbench for the read TLP path
// Completer model, request and completion stimulus, scoreboard arrays,
// checking assertions, watchdog and final report
`timescale 1ns/1ps

module tb_rd_tlp;

    localparam int N_TESTS = 6;
    localparam int WATCHDOG_NS = (N_TESTS * 200 + 1000) * 10;

    logic clk;
    logic reset_n;

    logic rd_req_valid;
    rd_tlp_pkg::t_rd_req rd_req;
    logic rd_req_ready;
    logic tx_tlp_valid;
    rd_tlp_pkg::t_mrd_hdr tx_tlp;
    logic tx_tlp_ready;
    logic rx_cpl_valid;
    rd_tlp_pkg::t_cpl_beat rx_cpl;
    logic rx_cpl_ready;
    logic rd_rsp_valid;
    rd_tlp_pkg::t_rd_rsp rd_rsp;
    logic rd_rsp_ready;
    logic tag_available;

    // Stall control for the two output streams
    logic stall_en;
    logic tx_go;
    logic rsp_go;
    logic drop_phase;

    logic tx_fire;
    logic rsp_fire;

    // Request log in issue order
    rd_tlp_pkg::t_rd_req req_mem [256];
    logic [7:0] req_wr;
    logic [7:0] tlp_rd;
    rd_tlp_pkg::t_rd_req exp_req;
    rd_tlp_pkg::t_mrd_hdr exp_hdr;

    // Per accelerator tag state of reads in flight
    logic [255:0] afu_busy;
    logic [15:0] tag_busy;
    rd_tlp_pkg::t_tag tag_of_afu [256];
    logic [2:0] lc_of_afu [256];
    logic [2:0] next_line [256];
    logic exp_last;
    rd_tlp_pkg::t_line_data exp_data;
    int n_out;
    int tlp_count;

    // Tags the completer model took from tx_tlp and their lengths
    rd_tlp_pkg::t_tag pend_tag [256];
    rd_tlp_pkg::t_dw_len cmp_len [16];
    logic [7:0] cmp_wr;
    logic [7:0] cmp_rd;

    logic [7:0] afu_next;
    int err_count;
    int errs_at_start;
    int n_tests;
    int n_passed;

    tb_clock_gen u_clock_gen (.clk, .reset_n);

    rd_tlp_top u_dut (
        .clk, .reset_n,
        .rd_req_valid, .rd_req, .rd_req_ready,
        .tx_tlp_valid, .tx_tlp, .tx_tlp_ready,
        .rx_cpl_valid, .rx_cpl, .rx_cpl_ready,
        .rd_rsp_valid, .rd_rsp, .rd_rsp_ready,
        .tag_available);

    // ========================================
    // Helpers
    // ========================================

    // Payload the completer returns for one line of a tag
    function automatic rd_tlp_pkg::t_line_data line_data(input rd_tlp_pkg::t_tag tag,
                                                         input int line);
        logic [7:0] key;
        key = {tag, 4'(line)};
        return {4{key ^ 8'h5a, key, ~key, 8'(key * 8'd37)}};
    endfunction

    function automatic logic [63:0] random_addr(input logic wide);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = 32'h0;
        // One high-word bit at a random position
        if (wide)
        begin
            hi = 32'h1 << $urandom_range(31, 0);
        end
        lo = $urandom & 32'hffff_fff0;
        return {hi, lo};
    endfunction

    task automatic report_error(input string msg);
        err_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (err_count == errs_at_start)
        begin
            n_passed++;
            $display("test %0d %s: passed", n_tests, name);
        end
        else
        begin
            $display("test %0d %s: failed, %0d error(s)", n_tests, name,
                     err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic send_req(input logic [63:0] addr, input rd_tlp_pkg::t_line_count lc);
        rd_req.addr = addr;
        rd_req.afu_tag = afu_next;
        rd_req.line_count = lc;
        rd_req_valid = 1'b1;
        afu_next = afu_next + 8'd1;
        while (!rd_req_ready)
        begin
            @(negedge clk);
        end
        @(negedge clk);
        rd_req_valid = 1'b0;
    endtask

    task automatic send_cpl_beat(input rd_tlp_pkg::t_cpl_beat beat);
        rx_cpl = beat;
        rx_cpl_valid = 1'b1;
        while (!rx_cpl_ready)
        begin
            @(negedge clk);
        end
        @(negedge clk);
        rx_cpl_valid = 1'b0;
    endtask

    task automatic send_packet(input logic [7:0] fmt, input rd_tlp_pkg::t_tag tag,
                               input int nbeats, input rd_tlp_pkg::t_dw_len len_dw,
                               input logic [11:0] byte_count, input int first_line);
        rd_tlp_pkg::t_cpl_beat beat;
        for (int i = 0; i < nbeats; i++)
        begin
            beat.sop = (i == 0);
            beat.eop = (i == nbeats - 1);
            beat.fmttype = fmt;
            beat.length = len_dw;
            beat.tag = tag;
            beat.byte_count = byte_count;
            beat.data = line_data(tag, first_line + i);
            send_cpl_beat(beat);
        end
    endtask

    // Whole read, or split in two halves with the remaining byte count
    task automatic complete_read(input rd_tlp_pkg::t_tag tag, input logic split);
        int lc;
        int first;
        lc = int'(cmp_len[tag]) / 4;
        first = (split && lc >= 2) ? lc / 2 : lc;
        send_packet(rd_tlp_pkg::FMT_CPLD, tag, first, 10'(first * 4), 12'(lc * 16), 0);
        if (first < lc)
        begin
            send_packet(rd_tlp_pkg::FMT_CPLD, tag, lc - first, 10'((lc - first) * 4),
                        12'((lc - first) * 16), first);
        end
    endtask

    // Split mode 0 never, 1 always, 2 random
    task automatic complete_reads(input int n, input int split_mode);
        rd_tlp_pkg::t_tag tag;
        logic split;
        for (int k = 0; k < n; k++)
        begin
            wait (cmp_wr != cmp_rd);
            @(negedge clk);
            tag = pend_tag[cmp_rd];
            cmp_rd = cmp_rd + 8'd1;
            split = (split_mode == 1) || (split_mode == 2 && $urandom_range(1, 0) == 1);
            complete_read(tag, split);
        end
    endtask

    task automatic wait_reads_done();
        wait (n_out == 0 && cmp_wr == cmp_rd);
        @(negedge clk);
    endtask

    // ========================================
    // Ready stalls and scoreboard
    // ========================================

    always @(negedge clk)
    begin
        tx_go <= ($urandom_range(3, 0) != 0);
        rsp_go <= ($urandom_range(2, 0) != 0);
    end

    assign tx_tlp_ready = !stall_en || tx_go;
    assign rd_rsp_ready = !stall_en || rsp_go;
    assign tx_fire = tx_tlp_valid && tx_tlp_ready;
    assign rsp_fire = rd_rsp_valid && rd_rsp_ready;

    // Expected header straight from the format rules
    always_comb
    begin
        exp_req = req_mem[tlp_rd];
        exp_hdr.fmttype = (exp_req.addr[63:32] != 32'h0) ? rd_tlp_pkg::FMT_MRD64
                                                         : rd_tlp_pkg::FMT_MRD32;
        exp_hdr.length = 10'(exp_req.line_count) * 10'd4;
        exp_hdr.tag = tx_tlp.tag;
        exp_hdr.addr = exp_req.addr;
        exp_hdr.first_be = 4'hf;
        exp_hdr.last_be = 4'hf;
        exp_last = (next_line[rd_rsp.afu_tag] + 3'd1 == lc_of_afu[rd_rsp.afu_tag]);
        exp_data = line_data(tag_of_afu[rd_rsp.afu_tag], int'(next_line[rd_rsp.afu_tag]));
    end

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_wr <= 8'd0;
            tlp_rd <= 8'd0;
            afu_busy <= '0;
            tag_busy <= '0;
            n_out <= 0;
            tlp_count <= 0;
        end
        else
        begin
            if (rd_req_valid && rd_req_ready)
            begin
                req_mem[req_wr] <= rd_req;
                req_wr <= req_wr + 8'd1;
            end
            if (tx_fire)
            begin
                tlp_rd <= tlp_rd + 8'd1;
                tag_busy[tx_tlp.tag] <= 1'b1;
                afu_busy[exp_req.afu_tag] <= 1'b1;
                tag_of_afu[exp_req.afu_tag] <= tx_tlp.tag;
                lc_of_afu[exp_req.afu_tag] <= exp_req.line_count;
                next_line[exp_req.afu_tag] <= 3'd0;
            end
            if (rsp_fire)
            begin
                next_line[rd_rsp.afu_tag] <= next_line[rd_rsp.afu_tag] + 3'd1;
                // Read finished so its tag goes back to the pool
                if (rd_rsp.last)
                begin
                    afu_busy[rd_rsp.afu_tag] <= 1'b0;
                    tag_busy[tag_of_afu[rd_rsp.afu_tag]] <= 1'b0;
                end
            end
            n_out <= n_out + int'(tx_fire) - int'(rsp_fire && rd_rsp.last);
            tlp_count <= tlp_count + int'(tx_fire);
        end
    end

    // Completer records every TLP it takes
    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            cmp_wr <= 8'd0;
        end
        else if (tx_fire)
        begin
            pend_tag[cmp_wr] <= tx_tlp.tag;
            cmp_len[tx_tlp.tag] <= tx_tlp.length;
            cmp_wr <= cmp_wr + 8'd1;
        end
    end

    // ========================================
    // Checks
    // ========================================

    a_tlp_header: assert property (@(posedge clk) disable iff (!reset_n)
        tx_fire |-> tx_tlp == exp_hdr)
        else report_error($sformatf("tlp header %h, expected %h", tx_tlp, exp_hdr));

    a_tlp_tag_unique: assert property (@(posedge clk) disable iff (!reset_n)
        tx_fire |-> !tag_busy[tx_tlp.tag])
        else report_error($sformatf("tag %0d issued while still outstanding", tx_tlp.tag));

    a_tlp_stable: assert property (@(posedge clk) disable iff (!reset_n)
        tx_tlp_valid && !tx_tlp_ready |=> tx_tlp_valid && $stable(tx_tlp))
        else report_error("tlp dropped or changed while held");

    a_rsp_known: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_fire |-> afu_busy[rd_rsp.afu_tag])
        else report_error($sformatf("response for idle afu tag %0d", rd_rsp.afu_tag));

    a_rsp_line: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_fire |-> 3'(rd_rsp.line_idx) == next_line[rd_rsp.afu_tag])
        else report_error($sformatf("line index %0d, expected %0d", rd_rsp.line_idx,
                                    next_line[rd_rsp.afu_tag]));

    a_rsp_last: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_fire |-> rd_rsp.last == exp_last)
        else report_error($sformatf("last flag %0b, expected %0b", rd_rsp.last, exp_last));

    a_rsp_data: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_fire |-> rd_rsp.data == exp_data)
        else report_error($sformatf("response data %h, expected %h", rd_rsp.data, exp_data));

    a_rsp_stable: assert property (@(posedge clk) disable iff (!reset_n)
        rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp))
        else report_error("response dropped or changed while held");

    // Nothing answers a dropped packet
    a_drop_silent: assert property (@(posedge clk) disable iff (!reset_n)
        drop_phase |-> !rd_rsp_valid)
        else report_error("response beat produced by a dropped packet");

    // ========================================
    // Stimulus
    // ========================================

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a test stopped making progress",
                 WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        int base;
        void'($urandom(32'haeef_2a56));
        rd_req_valid = 1'b0;
        rd_req = '0;
        rx_cpl_valid = 1'b0;
        rx_cpl = '0;
        stall_en = 1'b0;
        drop_phase = 1'b0;
        cmp_rd = 8'd0;
        afu_next = 8'd0;
        err_count = 0;
        errs_at_start = 0;
        n_tests = 0;
        n_passed = 0;
        wait (reset_n);
        @(negedge clk);
        if (tx_tlp_valid || rd_rsp_valid)
        begin
            report_error("output valid high right after reset");
        end
        wait (tag_available);
        @(negedge clk);

        // Header form with 32 and 64 bit addresses alternating
        for (int i = 0; i < 6; i++)
        begin
            send_req(random_addr(i % 2 == 0), 3'($urandom_range(4, 1)));
        end
        complete_reads(6, 0);
        wait_reads_done();
        end_test("header form");

        // Tag limit with a silent completer and two requests beyond the pool
        base = tlp_count;
        for (int i = 0; i < 18; i++)
        begin
            send_req(random_addr(1'b0), 3'd1);
        end
        wait (tlp_count == base + 16);
        wait (!tag_available);
        repeat (20) @(negedge clk);
        if (tlp_count != base + 16)
        begin
            report_error($sformatf("%0d tlps with all tags busy", tlp_count - base));
        end
        complete_reads(1, 0);
        wait (tlp_count == base + 17);
        repeat (20) @(negedge clk);
        if (tlp_count != base + 17)
        begin
            report_error($sformatf("%0d tlps after one tag freed", tlp_count - base));
        end
        complete_reads(17, 0);
        wait_reads_done();
        end_test("tag limit");

        for (int i = 0; i < 4; i++)
        begin
            send_req(random_addr(1'b0), 3'(i + 1));
        end
        complete_reads(4, 0);
        wait_reads_done();
        end_test("unsplit read");

        // Byte counts 64 then 32
        send_req(random_addr(1'b1), 3'd4);
        complete_reads(1, 1);
        wait_reads_done();
        end_test("split read");

        drop_phase = 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            send_packet(rd_tlp_pkg::FMT_CPL, 4'($urandom_range(15, 0)), 1, 10'd0, 12'd0, 0);
            // Two-beat memory write packet
            send_packet(8'h40, 4'($urandom_range(15, 0)), 2, 10'd8, 12'd0, 0);
        end
        repeat (10) @(negedge clk);
        drop_phase = 1'b0;
        end_test("dropped packets");

        stall_en = 1'b1;
        fork
            for (int i = 0; i < 16; i++)
            begin
                send_req(random_addr($urandom_range(1, 0) == 1), 3'($urandom_range(4, 1)));
            end
            complete_reads(16, 2);
        join
        wait_reads_done();
        stall_en = 1'b0;
        end_test("back-pressure");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_passed, n_tests - n_passed, err_count);
        if (err_count == 0 && n_passed == n_tests)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 10 ns clock, synchronous active-low reset held for 3 cycles
`timescale 1ns/1ps

module tb_clock_gen
   (
    output logic clk,
    output logic reset_n
    );

    localparam int PERIOD_NS = 10;
    localparam int RESET_CYCLES = 3;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Release on a falling edge, away from the sampling edge
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

/* rd_tlp_top.sv */
// Read TLP path top level
// Request and completion buffers, tag tracker, request header
// generator and completion processor
`timescale 1ns/1ps

module rd_tlp_top
   (
    input  logic clk,
    input  logic reset_n,

    input  logic rd_req_valid,
    input  rd_tlp_pkg::t_rd_req rd_req,
    output logic rd_req_ready,

    output logic tx_tlp_valid,
    output rd_tlp_pkg::t_mrd_hdr tx_tlp,
    input  logic tx_tlp_ready,

    input  logic rx_cpl_valid,
    input  rd_tlp_pkg::t_cpl_beat rx_cpl,
    output logic rx_cpl_ready,

    output logic rd_rsp_valid,
    output rd_tlp_pkg::t_rd_rsp rd_rsp,
    input  logic rd_rsp_ready,

    output logic tag_available
    );

    rd_tlp_pkg::t_rd_req_buf req_in;
    logic req_buf_valid;
    rd_tlp_pkg::t_rd_req_buf req_buf;
    logic req_buf_ready;

    logic cpl_buf_valid;
    rd_tlp_pkg::t_cpl_beat cpl_buf;
    logic cpl_buf_ready;

    logic alloc;
    rd_tlp_pkg::t_rd_meta alloc_meta;
    logic alloc_ok;
    rd_tlp_pkg::t_tag alloc_tag;
    rd_tlp_pkg::t_tag lookup_tag;
    rd_tlp_pkg::t_rd_meta lookup_meta;
    logic free;
    rd_tlp_pkg::t_tag free_tag;

    // ========================================
    // Input buffers
    // ========================================

    // Reduce the high address word before buffering
    always_comb
    begin
        req_in.req = rd_req;
        req_in.is_addr64 = |rd_req.addr[63:32];
    end

    rd_stream_fifo #(.t_payload(rd_tlp_pkg::t_rd_req_buf)) u_req_buf (
        .clk, .reset_n,
        .in_valid(rd_req_valid), .in_data(req_in), .in_ready(rd_req_ready),
        .out_valid(req_buf_valid), .out_data(req_buf), .out_ready(req_buf_ready));

    rd_stream_fifo #(.t_payload(rd_tlp_pkg::t_cpl_beat)) u_cpl_buf (
        .clk, .reset_n,
        .in_valid(rx_cpl_valid), .in_data(rx_cpl), .in_ready(rx_cpl_ready),
        .out_valid(cpl_buf_valid), .out_data(cpl_buf), .out_ready(cpl_buf_ready));

    // ========================================
    // Tags, request TLPs, completions
    // ========================================

    rd_tag_tracker u_tag_tracker (
        .clk, .reset_n,
        .alloc, .alloc_meta, .alloc_ok, .alloc_tag,
        .lookup_tag, .lookup_meta,
        .free, .free_tag,
        .tag_available);

    rd_req_tlp_gen u_req_tlp_gen (
        .clk, .reset_n,
        .req_valid(req_buf_valid), .req(req_buf), .req_ready(req_buf_ready),
        .alloc_ok, .alloc_tag, .alloc, .alloc_meta,
        .tlp_valid(tx_tlp_valid), .tlp(tx_tlp), .tlp_ready(tx_tlp_ready));

    rd_cpl_proc u_cpl_proc (
        .clk, .reset_n,
        .cpl_valid(cpl_buf_valid), .cpl(cpl_buf), .cpl_ready(cpl_buf_ready),
        .lookup_tag, .lookup_meta,
        .free, .free_tag,
        .rsp_valid(rd_rsp_valid), .rsp(rd_rsp), .rsp_ready(rd_rsp_ready));

    // Data-less completions only ever target tags not in flight
    a_no_cpl_for_allocated: assert property (@(posedge clk) disable iff (!reset_n)
        cpl_buf_valid && cpl_buf_ready && cpl_buf.sop &&
        (cpl_buf.fmttype == rd_tlp_pkg::FMT_CPL) |-> u_tag_tracker.free_map[cpl_buf.tag]);

endmodule

/* rd_cpl_proc.sv */
// Completion beat parser and read response driver
// Tracks multi-beat packets, derives line indices from the remaining
// byte count and frees the tag after the final response beat
`timescale 1ns/1ps

module rd_cpl_proc
   (
    input  logic clk,
    input  logic reset_n,

    input  logic cpl_valid,
    input  rd_tlp_pkg::t_cpl_beat cpl,
    output logic cpl_ready,

    output rd_tlp_pkg::t_tag lookup_tag,
    input  rd_tlp_pkg::t_rd_meta lookup_meta,

    output logic free,
    output rd_tlp_pkg::t_tag free_tag,

    output logic rsp_valid,
    output rd_tlp_pkg::t_rd_rsp rsp,
    input  logic rsp_ready
    );

    // Per-beat decode, valid on SOP and continuation beats alike
    logic active;
    logic is_last;
    rd_tlp_pkg::t_afu_tag afu_tag;
    rd_tlp_pkg::t_line_idx line_idx;
    rd_tlp_pkg::t_tag tlp_tag;
    // Lines still owed, this packet included
    rd_tlp_pkg::t_line_count rem_lines;

    // State carried from SOP to later beats of the same packet
    logic reg_active;
    logic reg_is_last;
    rd_tlp_pkg::t_afu_tag reg_afu_tag;
    rd_tlp_pkg::t_line_idx reg_line_idx;
    rd_tlp_pkg::t_tag reg_tlp_tag;

    // PCIe tag of the beat in the response register
    rd_tlp_pkg::t_tag rsp_tlp_tag;

    // Stop draining while a response is held
    assign cpl_ready = !rsp_valid || rsp_ready;

    assign lookup_tag = cpl.tag;

    // ========================================
    // Beat decode
    // ========================================

    always_comb
    begin
        rem_lines = rd_tlp_pkg::t_line_count'(cpl.byte_count / 12'(rd_tlp_pkg::LINE_BYTES));
        if (cpl.sop)
        begin
            // Other packet kinds are consumed without a response
            active = (cpl.fmttype == rd_tlp_pkg::FMT_CPLD);
            // Final packet when nothing beyond this one is owed
            // (length in dwords, byte_count in bytes)
            is_last = (cpl.byte_count == {cpl.length, 2'b00});
            afu_tag = lookup_meta.afu_tag;
            // Split reads keep a continuous index
            line_idx = rd_tlp_pkg::t_line_idx'(lookup_meta.line_count - rem_lines);
            tlp_tag = cpl.tag;
        end
        else
        begin
            active = reg_active;
            is_last = reg_is_last;
            afu_tag = reg_afu_tag;
            line_idx = reg_line_idx + 2'd1;
            tlp_tag = reg_tlp_tag;
        end

        // Idle cycle, possibly between beats of one packet
        if (!cpl_valid)
        begin
            active = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpl_valid && cpl_ready)
        begin
            reg_is_last <= is_last;
            reg_afu_tag <= afu_tag;
            reg_line_idx <= line_idx;
            reg_tlp_tag <= tlp_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            reg_active <= 1'b0;
        end
        else if (cpl_valid && cpl_ready)
        begin
            reg_active <= active && !cpl.eop;
        end
    end

    // ========================================
    // Response and tag release
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
        end
        else if (cpl_ready)
        begin
            rsp_valid <= active;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpl_ready)
        begin
            rsp.afu_tag <= afu_tag;
            rsp.line_idx <= line_idx;
            // Only the EOP beat of the final packet ends the read
            rsp.last <= is_last && cpl.eop;
            rsp.data <= cpl.data;
            rsp_tlp_tag <= tlp_tag;
        end
    end

    assign free = rsp_valid && rsp_ready && rsp.last;
    assign free_tag = rsp_tlp_tag;

    // A new packet may not start before the previous one ended
    a_no_sop_mid_packet: assert property (@(posedge clk) disable iff (!reset_n)
        cpl_valid && cpl.sop |-> !reg_active);

endmodule

/* rd_req_tlp_gen.sv */
// Memory read TLP header builder
// Dequeues a buffered request once a tag is free and the output
// register can take a header, then holds it under back-pressure
`timescale 1ns/1ps

module rd_req_tlp_gen
   (
    input  logic clk,
    input  logic reset_n,

    input  logic req_valid,
    input  rd_tlp_pkg::t_rd_req_buf req,
    output logic req_ready,

    input  logic alloc_ok,
    input  rd_tlp_pkg::t_tag alloc_tag,
    output logic alloc,
    output rd_tlp_pkg::t_rd_meta alloc_meta,

    output logic tlp_valid,
    output rd_tlp_pkg::t_mrd_hdr tlp,
    input  logic tlp_ready
    );

    // Output register empty or draining this cycle
    logic out_free;
    rd_tlp_pkg::t_mrd_hdr hdr;

    assign out_free = !tlp_valid || tlp_ready;
    assign req_ready = alloc_ok && out_free;

    // Tag is taken on the same edge as the dequeue
    assign alloc = req_valid && req_ready;

    // Returned with every response line of this read
    always_comb
    begin
        alloc_meta.afu_tag = req.req.afu_tag;
        alloc_meta.line_count = req.req.line_count;
    end

    // ========================================
    // Header
    // ========================================

    always_comb
    begin
        // MRd64 is not allowed when the address fits in 32 bits
        hdr.fmttype = req.is_addr64 ? rd_tlp_pkg::FMT_MRD64 : rd_tlp_pkg::FMT_MRD32;
        // Four dwords per line
        hdr.length = rd_tlp_pkg::t_dw_len'(req.req.line_count) *
                     rd_tlp_pkg::t_dw_len'(rd_tlp_pkg::DWORDS_PER_LINE);
        hdr.tag = alloc_tag;
        hdr.addr = req.req.addr;
        // Whole lines only, every byte enabled
        hdr.first_be = 4'b1111;
        hdr.last_be = 4'b1111;
    end

    // Holding register toward the TLP stream
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tlp_valid <= 1'b0;
        end
        else if (out_free)
        begin
            tlp_valid <= alloc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            tlp <= hdr;
        end
    end

endmodule

/* rd_tag_tracker.sv */
// PCIe tag allocator with a free bitmap, lowest free tag first
// Tag-indexed metadata store with combinational lookup
// Registered tag-available flag
`timescale 1ns/1ps

module rd_tag_tracker
   (
    input  logic clk,
    input  logic reset_n,

    input  logic alloc,
    input  rd_tlp_pkg::t_rd_meta alloc_meta,
    output logic alloc_ok,
    output rd_tlp_pkg::t_tag alloc_tag,

    input  rd_tlp_pkg::t_tag lookup_tag,
    output rd_tlp_pkg::t_rd_meta lookup_meta,

    input  logic free,
    input  rd_tlp_pkg::t_tag free_tag,

    output logic tag_available
    );

    // ========================================
    // Free list
    // ========================================

    // One bit per tag, set while the tag is free
    logic [rd_tlp_pkg::N_TAGS-1:0] free_map;
    logic [rd_tlp_pkg::N_TAGS-1:0] free_map_next;

    assign alloc_ok = |free_map;

    // Lowest free tag wins
    always_comb
    begin
        alloc_tag = '0;
        for (int i = rd_tlp_pkg::N_TAGS - 1; i >= 0; i--)
        begin
            if (free_map[i])
            begin
                alloc_tag = rd_tlp_pkg::t_tag'(i);
            end
        end
    end

    // Alloc and free never name the same tag in one cycle
    always_comb
    begin
        free_map_next = free_map;
        if (alloc)
        begin
            free_map_next[alloc_tag] = 1'b0;
        end
        if (free)
        begin
            free_map_next[free_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            free_map <= '1;
            tag_available <= 1'b0;
        end
        else
        begin
            free_map <= free_map_next;
            // Follows the free map of the coming cycle
            tag_available <= |free_map_next;
        end
    end

    // ========================================
    // Metadata store
    // ========================================

    rd_tlp_pkg::t_rd_meta meta_mem [rd_tlp_pkg::N_TAGS];

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            meta_mem[alloc_tag] <= alloc_meta;
        end
    end

    assign lookup_meta = meta_mem[lookup_tag];

    // Generator must wait for a free tag
    a_alloc_needs_tag: assert property (@(posedge clk) disable iff (!reset_n)
        alloc |-> alloc_ok);

    // Completion side frees only tags that were handed out
    a_no_double_free: assert property (@(posedge clk) disable iff (!reset_n)
        free |-> !free_map[free_tag]);

endmodule

/* rd_stream_fifo.sv */
// Two-entry valid/ready buffer, payload type set by parameter
// Full throughput with ready derived from the fill count register
`timescale 1ns/1ps

module rd_stream_fifo
  #(
    parameter type t_payload = logic
    )
   (
    input  logic clk,
    input  logic reset_n,

    input  logic in_valid,
    input  t_payload in_data,
    output logic in_ready,

    output logic out_valid,
    output t_payload out_data,
    input  logic out_ready
    );

    // Storage slots and ring pointers
    t_payload slots [2];
    logic wr_ptr;
    logic rd_ptr;
    // Number of items held (0 to 2)
    logic [1:0] count;

    logic enq;
    logic deq;

    // Ready depends only on registered state
    assign in_ready = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data = slots[rd_ptr];

    assign enq = in_valid && in_ready;
    assign deq = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (deq)
            begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, enq} - {1'b0, deq};
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            slots[wr_ptr] <= in_data;
        end
    end

    // Enqueue never lands on the slot still waiting at the head
    a_no_enq_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        enq && (count != 2'd0) |-> (count == 2'd1) && (wr_ptr != rd_ptr));

endmodule

/* rd_tlp_pkg.sv */
// Sizes, PCIe format/type codes and packed stream payloads
// shared by the read request and read completion paths
package rd_tlp_pkg;

    // ========================================
    // Sizes
    // ========================================

    // PCIe tags outstanding at once
    localparam int N_TAGS = 16;
    localparam int TAG_BITS = $clog2(N_TAGS);

    // Accelerator request tag width
    localparam int AFU_TAG_BITS = 8;

    // One line is one bus beat
    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS = LINE_BYTES * 8;
    localparam int DWORDS_PER_LINE = LINE_BYTES / 4;

    // ========================================
    // PCIe format/type codes
    // ========================================

    localparam logic [7:0] FMT_MRD32 = 8'h00;
    localparam logic [7:0] FMT_MRD64 = 8'h20;
    // Completion without data
    localparam logic [7:0] FMT_CPL = 8'h0A;
    localparam logic [7:0] FMT_CPLD = 8'h4A;

    // ========================================
    // Types
    // ========================================

    typedef logic [TAG_BITS-1:0] t_tag;
    typedef logic [AFU_TAG_BITS-1:0] t_afu_tag;
    // Lines per request, 1 to 4
    typedef logic [2:0] t_line_count;
    // Line position inside one request
    typedef logic [1:0] t_line_idx;
    typedef logic [LINE_BITS-1:0] t_line_data;
    // TLP length field in dwords
    typedef logic [9:0] t_dw_len;

    // Read request from the accelerator
    typedef struct packed {
        logic [63:0] addr;
        t_afu_tag afu_tag;
        t_line_count line_count;
    } t_rd_req;

    // Buffered request, high address word already reduced
    typedef struct packed {
        t_rd_req req;
        logic is_addr64;
    } t_rd_req_buf;

    // Memory read request header
    typedef struct packed {
        logic [7:0] fmttype;
        t_dw_len length;
        t_tag tag;
        logic [63:0] addr;
        logic [3:0] first_be;
        logic [3:0] last_be;
    } t_mrd_hdr;

    // One beat of the incoming completion stream
    typedef struct packed {
        logic sop;
        logic eop;
        logic [7:0] fmttype;
        t_dw_len length;
        t_tag tag;
        // Bytes still owed for the whole read, this packet included
        logic [11:0] byte_count;
        t_line_data data;
    } t_cpl_beat;

    // Per-line read response
    typedef struct packed {
        t_afu_tag afu_tag;
        t_line_idx line_idx;
        logic last;
        t_line_data data;
    } t_rd_rsp;

    // What is remembered per outstanding tag
    typedef struct packed {
        t_afu_tag afu_tag;
        t_line_count line_count;
    } t_rd_meta;

endpackage
